// File: rtl/board_cfg.svh
// Width, rate table, framebuffer base and timing macros for the board glue
`ifndef BOARD_CFG_SVH
`define BOARD_CFG_SVH

// ========================================
// Bus widths
// ========================================
`define MGMT_ADDR_W 32
`define MGMT_DATA_W 32
`define GEOM_START_W 20

// ========================================
// Framebuffer
// ========================================
// Upper ten bits of the DDR framebuffer window
`define FB_BASE_PREFIX {4'h3, 6'b111110}
// Fixed line width for 24-bit modes
`define FB_FIXED_WIDTH 12'd640

// ========================================
// Joystick timing and CPU clock rates
// ========================================
`define GRAV_STEP 40000
`define RATE_0 90000000
`define RATE_1 100000000
`define RATE_2 15000000
`define RATE_3 30000000
`define RATE_4 56250000

// Disk LED hold, roughly 50 ms at 90 MHz
`define LED_HOLD_DEFAULT 4500000

`endif

// File: rtl/board_pkg.sv
// Packed struct types shared by the board glue RTL and its testbench
`include "board_cfg.svh"

package board_pkg;

	// Host side, single-cycle strobes
	typedef struct packed {
		logic                    rd;
		logic                    wr;
		logic [`MGMT_ADDR_W-1:0] addr;
		logic [`MGMT_DATA_W-1:0] wdata;
	} host_req_t;

	// Management bus, master to slave
	typedef struct packed {
		logic                    read;
		logic                    write;
		logic [`MGMT_ADDR_W-1:0] address;
		logic [`MGMT_DATA_W-1:0] writedata;
	} mgmt_cmd_t;

	// Management bus, slave to master
	typedef struct packed {
		logic                    waitrequest;
		logic                    readdatavalid;
		logic [`MGMT_DATA_W-1:0] readdata;
	} mgmt_rsp_t;

	// Video core geometry and flags
	typedef struct packed {
		logic [`GEOM_START_W-1:0] start_addr;
		logic [8:0]               width;
		logic [8:0]               stride;
		logic [10:0]              height;
		logic [3:0]               flags;
		logic                     off;
	} vga_geom_t;

	// Framebuffer descriptor as seen by the scaler
	typedef struct packed {
		logic        en;
		logic [31:0] base;
		logic [11:0] width;
		logic [11:0] height;
		logic [13:0] stride;
		logic [4:0]  format;
		logic        force_blank;
	} fb_desc_t;

	typedef struct packed {
		logic [7:0]  addr;
		logic [17:0] data;
		logic        wr;
	} pal_raw_t;

	typedef struct packed {
		logic [7:0]  addr;
		logic [23:0] data;
		logic        wr;
	} pal_fb_t;

endpackage

// File: rtl/host_bridge_ctrl.sv
// Host strobe to management bus bridge FSM with wait level and disk busy flags
`include "board_cfg.svh"

module host_bridge_ctrl (
	input  logic                    clk_sys,
	input  logic                    cpu_reset,
	input  board_pkg::host_req_t    host_req,
	input  logic                    disk_device,
	input  board_pkg::mgmt_rsp_t    mgmt_rsp,
	output board_pkg::mgmt_cmd_t    mgmt_cmd,
	output logic [`MGMT_DATA_W-1:0] host_rdata,
	output logic                    io_wait,
	output logic                    hdd_busy,
	output logic                    fdd_busy
);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_RD_ISSUE,
		ST_RD_WAIT,
		ST_WR_ISSUE,
		ST_WR_DONE
	} state_t;

	state_t                  state;
	logic                    cmd_rd;
	logic                    cmd_wr;
	logic [`MGMT_ADDR_W-1:0] cmd_addr;
	logic [`MGMT_DATA_W-1:0] cmd_wdata;

	// Address and data latched with the host strobe
	always_ff @(posedge clk_sys) begin
		if (host_req.rd || host_req.wr) begin
			cmd_addr  <= host_req.addr;
			cmd_wdata <= host_req.wdata;
		end
	end

	// ========================================
	// Transfer sequencing
	// ========================================
	always_ff @(posedge clk_sys) begin
		if (cpu_reset) begin
			state      <= ST_IDLE;
			io_wait    <= 1'b0;
			cmd_rd     <= 1'b0;
			cmd_wr     <= 1'b0;
			host_rdata <= '0;
		end else begin
			// Everything holds while the slave stalls
			if (!mgmt_rsp.waitrequest) begin
				cmd_rd <= 1'b0;
				cmd_wr <= 1'b0;
				case (state)
					ST_RD_ISSUE: begin
						cmd_rd <= 1'b1;
						state  <= ST_RD_WAIT;
					end
					ST_RD_WAIT: begin
						if (mgmt_rsp.readdatavalid) begin
							host_rdata <= mgmt_rsp.readdata;
							io_wait    <= 1'b0;
							state      <= ST_IDLE;
						end
					end
					ST_WR_ISSUE: begin
						cmd_wr <= 1'b1;
						state  <= ST_WR_DONE;
					end
					ST_WR_DONE: begin
						io_wait <= 1'b0;
						state   <= ST_IDLE;
					end
					default: state <= ST_IDLE;
				endcase
			end

			// New strobes restart the sequence, write has priority
			if (host_req.rd) begin
				io_wait <= 1'b1;
				state   <= ST_RD_ISSUE;
			end
			if (host_req.wr) begin
				io_wait <= 1'b1;
				state   <= ST_WR_ISSUE;
			end
		end
	end

	assign mgmt_cmd = '{read: cmd_rd, write: cmd_wr, address: cmd_addr, writedata: cmd_wdata};

	assign hdd_busy = io_wait & disk_device;
	assign fdd_busy = io_wait & ~disk_device;

	a_rd_wr_exclusive: assert property (@(posedge clk_sys) disable iff (cpu_reset)
		!(cmd_rd && cmd_wr));

endmodule

// File: rtl/fb_descriptor.sv
// Registered framebuffer descriptor and 18 to 24 bit palette widening
`include "board_cfg.svh"

module fb_descriptor (
	input  logic                  clk_sys,
	input  logic                  cpu_reset,
	input  board_pkg::vga_geom_t  geom,
	input  logic                  rgb_order,
	input  logic                  fmt_565,
	input  board_pkg::pal_raw_t   pal_in,
	output board_pkg::fb_desc_t   fb,
	output board_pkg::pal_fb_t    pal_out
);

	board_pkg::fb_desc_t fb_next;
	logic [1:0]          mode;

	assign mode = geom.flags[1:0];

	// ========================================
	// Descriptor fields
	// ========================================
	always_comb begin
		fb_next.en   = (mode != 2'd0) && !geom.flags[2];
		fb_next.base = {`FB_BASE_PREFIX, geom.start_addr, 2'b00};

		// Bytes per line depend on pixel depth
		if (mode == 2'd3)
			fb_next.width = `FB_FIXED_WIDTH;
		else if (geom.flags[2])
			fb_next.width = {1'b0, geom.width, 2'b00};
		else
			fb_next.width = {geom.width, 3'b000};

		fb_next.stride = {2'b00, geom.stride, 3'b000};

		// Line doubling halves the visible height
		if (geom.flags[3])
			fb_next.height = {2'b00, geom.height[10:1]};
		else
			fb_next.height = {1'b0, geom.height};

		// 101 = 24bpp, 100 = 16bpp, 011 = 8bpp palette
		case (mode)
			2'd3:    fb_next.format[2:0] = 3'b101;
			2'd2:    fb_next.format[2:0] = 3'b100;
			default: fb_next.format[2:0] = 3'b011;
		endcase
		fb_next.format[4:3] = {~rgb_order, ~fmt_565};

		fb_next.force_blank = geom.off;
	end

	always_ff @(posedge clk_sys) begin
		fb <= fb_next;
		if (cpu_reset) begin
			fb.en          <= 1'b0;
			fb.force_blank <= 1'b0;
		end
	end

	// Each 6-bit channel gets its top two bits repeated below it
	assign pal_out = '{
		addr: pal_in.addr,
		data: {pal_in.data[17:12], pal_in.data[17:16],
		       pal_in.data[11:6], pal_in.data[11:10],
		       pal_in.data[5:0], pal_in.data[5:4]},
		wr:   pal_in.wr
	};

	a_en_flag2_clear: assert property (@(posedge clk_sys) disable iff (cpu_reset)
		fb.en |-> !$past(geom.flags[2]));

endmodule

// File: rtl/gravis_clock_gen.sv
// Rate table lookup and phase accumulator for the joystick timing clock
`include "board_cfg.svh"

module gravis_clock_gen #(
	parameter int STEP = `GRAV_STEP
) (
	input  logic       clk_sys,
	input  logic       cpu_reset,
	input  logic [2:0] speed_sel,
	output logic       grav_clk
);

	logic [31:0] rate;
	logic [31:0] acc;
	logic [31:0] sum;

	// Codes past the table fall back to the default speed
	always_comb begin
		case (speed_sel)
			3'd1:    rate = 32'(`RATE_1);
			3'd2:    rate = 32'(`RATE_2);
			3'd3:    rate = 32'(`RATE_3);
			3'd4:    rate = 32'(`RATE_4);
			default: rate = 32'(`RATE_0);
		endcase
	end

	assign sum = acc + 32'(STEP);

	always_ff @(posedge clk_sys) begin
		if (cpu_reset) begin
			acc      <= '0;
			grav_clk <= 1'b0;
		end else if (sum >= rate) begin
			// A drop to a slower rate can leave sum far above it
			acc      <= (sum >= (rate << 1)) ? '0 : sum - rate;
			grav_clk <= ~grav_clk;
		end else begin
			acc <= sum;
		end
	end

	a_acc_below_rate: assert property (@(posedge clk_sys) disable iff (cpu_reset)
		acc < $past(rate));

endmodule

// File: rtl/activity_led.sv
// Retriggerable pulse stretcher driving one disk activity LED
`include "board_cfg.svh"

module activity_led #(
	parameter int HOLD_CYCLES = `LED_HOLD_DEFAULT
) (
	input  logic clk_sys,
	input  logic cpu_reset,
	input  logic trigger,
	output logic led
);

	localparam int CNT_W = $clog2(HOLD_CYCLES + 1);

	logic [CNT_W-1:0] count;

	// Every trigger cycle restarts the full hold
	always_ff @(posedge clk_sys) begin
		if (cpu_reset) begin
			count <= '0;
		end else if (trigger) begin
			count <= CNT_W'(HOLD_CYCLES);
		end else if (count != '0) begin
			count <= count - 1'b1;
		end
	end

	assign led = (count != '0);

endmodule

// File: rtl/board_glue_top.sv
// Board glue top level with host bridge, framebuffer descriptor, joystick clock and LEDs
`include "board_cfg.svh"

module board_glue_top #(
	parameter int LED_HOLD = `LED_HOLD_DEFAULT
) (
	input  logic                    clk_sys,
	input  logic                    cpu_reset,
	input  board_pkg::host_req_t    host_req,
	input  logic                    disk_device,
	input  board_pkg::mgmt_rsp_t    mgmt_rsp,
	input  board_pkg::vga_geom_t    geom,
	input  logic                    rgb_order,
	input  logic                    fmt_565,
	input  board_pkg::pal_raw_t     pal_in,
	input  logic [2:0]              speed_sel,
	output board_pkg::mgmt_cmd_t    mgmt_cmd,
	output logic [`MGMT_DATA_W-1:0] host_rdata,
	output logic                    io_wait,
	output board_pkg::fb_desc_t     fb,
	output board_pkg::pal_fb_t      pal_out,
	output logic                    grav_clk,
	output logic                    led_hdd,
	output logic                    led_fdd
);

	logic hdd_busy;
	logic fdd_busy;

	// ========================================
	// Control
	// ========================================
	host_bridge_ctrl bridge (
		.clk_sys     (clk_sys),
		.cpu_reset   (cpu_reset),
		.host_req    (host_req),
		.disk_device (disk_device),
		.mgmt_rsp    (mgmt_rsp),
		.mgmt_cmd    (mgmt_cmd),
		.host_rdata  (host_rdata),
		.io_wait     (io_wait),
		.hdd_busy    (hdd_busy),
		.fdd_busy    (fdd_busy)
	);

	// ========================================
	// Datapath
	// ========================================
	fb_descriptor fb_desc (
		.clk_sys   (clk_sys),
		.cpu_reset (cpu_reset),
		.geom      (geom),
		.rgb_order (rgb_order),
		.fmt_565   (fmt_565),
		.pal_in    (pal_in),
		.fb        (fb),
		.pal_out   (pal_out)
	);

	gravis_clock_gen grav_clk_gen (
		.clk_sys   (clk_sys),
		.cpu_reset (cpu_reset),
		.speed_sel (speed_sel),
		.grav_clk  (grav_clk)
	);

	activity_led #(.HOLD_CYCLES(LED_HOLD)) hdd_led (
		.clk_sys   (clk_sys),
		.cpu_reset (cpu_reset),
		.trigger   (hdd_busy),
		.led       (led_hdd)
	);

	activity_led #(.HOLD_CYCLES(LED_HOLD)) fdd_led (
		.clk_sys   (clk_sys),
		.cpu_reset (cpu_reset),
		.trigger   (fdd_busy),
		.led       (led_fdd)
	);

endmodule

// File: test/tb_board_glue.sv
// Board glue testbench with clock, reset, LFSR, management bus model, directed tests and timeout
`include "board_cfg.svh"

module tb_board_glue;

	// Joystick test runs 2 x ~3000 cycles, all other tests stay below 1000
	localparam int TIMEOUT_CYCLES = 10000;
	localparam logic [31:0] SEED = 32'h7c45_5578;

	logic                 clk_sys;
	logic                 cpu_reset;
	board_pkg::host_req_t host_req;
	logic                 disk_device;
	board_pkg::mgmt_rsp_t mgmt_rsp;
	board_pkg::vga_geom_t geom;
	logic                 rgb_order;
	logic                 fmt_565;
	board_pkg::pal_raw_t  pal_in;
	logic [2:0]           speed_sel;
	board_pkg::mgmt_cmd_t mgmt_cmd;
	logic [31:0]          host_rdata;
	logic                 io_wait;
	board_pkg::fb_desc_t  fb;
	board_pkg::pal_fb_t   pal_out;
	logic                 grav_clk;
	logic                 led_hdd;
	logic                 led_fdd;

	logic [31:0] stim_lfsr = SEED;
	logic [31:0] model_lfsr = SEED;
	int          value_errors = 0;
	int          other_errors = 0;
	int          cycle_count = 0;

	// Management bus model state
	logic        wait_en = 1'b0;
	logic        waits_on;
	logic        in_reset;
	logic        rd_pending = 1'b0;
	logic [31:0] model_bits;
	logic [2:0]  model_delay;
	int          wr_count = 0;
	int          rd_count = 0;
	int          valid_count = 0;
	logic [31:0] wr_addr;
	logic [31:0] wr_data;
	logic [31:0] rd_addr;
	logic [31:0] rd_value;

	board_glue_top #(.LED_HOLD(20)) UUT (
		.clk_sys     (clk_sys),
		.cpu_reset   (cpu_reset),
		.host_req    (host_req),
		.disk_device (disk_device),
		.mgmt_rsp    (mgmt_rsp),
		.geom        (geom),
		.rgb_order   (rgb_order),
		.fmt_565     (fmt_565),
		.pal_in      (pal_in),
		.speed_sel   (speed_sel),
		.mgmt_cmd    (mgmt_cmd),
		.host_rdata  (host_rdata),
		.io_wait     (io_wait),
		.fb          (fb),
		.pal_out     (pal_out),
		.grav_clk    (grav_clk),
		.led_hdd     (led_hdd),
		.led_fdd     (led_fdd)
	);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	// ========================================
	// Helpers
	// ========================================
	// Fibonacci LFSR, taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(inout logic [31:0] state, input int n, output logic [31:0] val);
		val = '0;
		for (int i = 0; i < n; i++) begin
			state = lfsr_step(state);
			val   = {val[30:0], state[0]};
		end
	endtask

	task automatic next_cycle();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic report_mismatch(input string test, input logic [79:0] exp,
		input logic [79:0] act);
		value_errors++;
		$display("Mismatch %s expected %h actual %h", test, exp, act);
	endtask

	task automatic report_failure(input string msg);
		other_errors++;
		$display("%s", msg);
	endtask

	function automatic board_pkg::fb_desc_t expected_fb(input board_pkg::vga_geom_t g,
		input logic rgb, input logic f565);
		board_pkg::fb_desc_t d;
		logic [1:0]          mode;
		mode          = g.flags[1:0];
		d.en          = (mode != 2'd0) && (g.flags[2] == 1'b0);
		d.base        = {`FB_BASE_PREFIX, g.start_addr, 2'b00};
		if (mode == 2'd3)
			d.width = 12'd640;
		else if (g.flags[2])
			d.width = 12'(g.width) * 12'd4;
		else
			d.width = 12'(g.width) * 12'd8;
		d.stride      = 14'(g.stride) * 14'd8;
		d.height      = g.flags[3] ? 12'(g.height) / 12'd2 : 12'(g.height);
		d.format      = {~rgb, ~f565, (mode == 2'd3) ? 3'b101 : (mode == 2'd2) ? 3'b100 : 3'b011};
		d.force_blank = g.off;
		return d;
	endfunction

	function automatic logic [23:0] widen_palette(input logic [17:0] d);
		logic [5:0]  c;
		logic [23:0] w;
		for (int i = 0; i < 3; i++) begin
			c            = d[6*i +: 6];
			w[8*i +: 8] = {c, c[5:4]};
		end
		return w;
	endfunction

	// One host strobe, then wait for the bridge to drop io_wait
	task automatic host_access(input logic is_write, input logic dev, input logic [31:0] addr,
		input logic [31:0] data, input string test);
		host_req    = '{rd: ~is_write, wr: is_write, addr: addr, wdata: data};
		disk_device = dev;
		next_cycle();
		host_req.rd = 1'b0;
		host_req.wr = 1'b0;
		if (io_wait !== 1'b1)
			report_mismatch({test, " io_wait after strobe"}, 80'd1, 80'(io_wait));
		while (io_wait)
			next_cycle();
	endtask

	// ========================================
	// Management bus slave model
	// ========================================
	always @(posedge clk_sys) begin
		in_reset = cpu_reset;
		waits_on = wait_en;
		#1;
		if (in_reset) begin
			mgmt_rsp   = '0;
			rd_pending = 1'b0;
		end else begin
			if (mgmt_cmd.read && mgmt_cmd.write)
				report_failure("Management read and write were issued in the same cycle");
			mgmt_rsp.readdatavalid = 1'b0;
			if (rd_pending && model_delay == 3'd0) begin
				mgmt_rsp.readdatavalid = 1'b1;
				mgmt_rsp.readdata      = rd_value;
				mgmt_rsp.waitrequest   = 1'b0;
				rd_pending             = 1'b0;
				valid_count++;
			end else begin
				if (rd_pending)
					model_delay = model_delay - 3'd1;
				take_bits(model_lfsr, 2, model_bits);
				mgmt_rsp.waitrequest = waits_on && (model_bits[1:0] == 2'b11);
			end
			// A command is accepted on an edge where wait request is low
			if (mgmt_cmd.write && !mgmt_rsp.waitrequest) begin
				wr_count++;
				wr_addr = mgmt_cmd.address;
				wr_data = mgmt_cmd.writedata;
			end
			if (mgmt_cmd.read && !mgmt_rsp.waitrequest) begin
				rd_count++;
				rd_addr    = mgmt_cmd.address;
				rd_pending = 1'b1;
				take_bits(model_lfsr, 3, model_bits);
				model_delay = model_bits[2:0];
				take_bits(model_lfsr, 32, rd_value);
			end
		end
	end

	// ========================================
	// Tests
	// ========================================
	task automatic test_reset_values();
		if ({io_wait, mgmt_cmd.read, mgmt_cmd.write, fb.en, fb.force_blank} !== 5'b0)
			report_mismatch("test_reset_values flags", 80'd0,
				80'({io_wait, mgmt_cmd.read, mgmt_cmd.write, fb.en, fb.force_blank}));
		if ({host_rdata, grav_clk, led_hdd, led_fdd} !== 35'd0)
			report_mismatch("test_reset_values outputs", 80'd0,
				80'({host_rdata, grav_clk, led_hdd, led_fdd}));
	endtask

	task automatic test_host_write();
		logic [31:0] addr;
		logic [31:0] data;
		int          wr_before;
		int          rd_before;
		for (int i = 0; i < 8; i++) begin
			wait_en = (i >= 4);
			take_bits(stim_lfsr, 32, addr);
			take_bits(stim_lfsr, 32, data);
			wr_before = wr_count;
			rd_before = rd_count;
			host_access(1'b1, addr[0], addr, data, "test_host_write");
			if (wr_count != wr_before + 1)
				report_mismatch("test_host_write writes", 80'(wr_before + 1), 80'(wr_count));
			if (rd_count != rd_before)
				report_mismatch("test_host_write reads", 80'(rd_before), 80'(rd_count));
			if ({wr_addr, wr_data} !== {addr, data})
				report_mismatch("test_host_write addr/data", 80'({addr, data}),
					80'({wr_addr, wr_data}));
			next_cycle();
			if (io_wait !== 1'b0)
				report_mismatch("test_host_write io_wait idle", 80'd0, 80'(io_wait));
		end
		wait_en = 1'b0;
	endtask

	task automatic test_host_read();
		logic [31:0] addr;
		int          rd_before;
		int          valid_before;
		for (int i = 0; i < 6; i++) begin
			wait_en = (i >= 3);
			take_bits(stim_lfsr, 32, addr);
			rd_before    = rd_count;
			valid_before = valid_count;
			host_access(1'b0, addr[0], addr, 32'd0, "test_host_read");
			if (rd_count != rd_before + 1 || rd_addr !== addr)
				report_mismatch("test_host_read accept", 80'({addr, 32'(rd_before + 1)}),
					80'({rd_addr, 32'(rd_count)}));
			if (valid_count != valid_before + 1)
				report_failure("test_host_read: io_wait fell before read data was valid");
			if (host_rdata !== rd_value)
				report_mismatch("test_host_read data", 80'(rd_value), 80'(host_rdata));
		end
		wait_en = 1'b0;
	endtask

	task automatic test_fb_descriptor();
		board_pkg::vga_geom_t g;
		board_pkg::fb_desc_t  exp;
		logic [31:0]          r;
		for (int i = 0; i < 20; i++) begin
			take_bits(stim_lfsr, 20, r);
			g.start_addr = r[19:0];
			take_bits(stim_lfsr, 18, r);
			g.width  = r[8:0];
			g.stride = r[17:9];
			take_bits(stim_lfsr, 16, r);
			g.height = r[10:0];
			g.flags  = r[14:11];
			g.off    = r[15];
			take_bits(stim_lfsr, 2, r);
			geom      = g;
			rgb_order = r[0];
			fmt_565   = r[1];
			next_cycle();
			next_cycle();
			exp = expected_fb(g, r[0], r[1]);
			if (fb !== exp)
				report_mismatch("test_fb_descriptor", 80'(exp), 80'(fb));
		end
	endtask

	task automatic test_palette();
		logic [31:0] r;
		for (int i = 0; i < 8; i++) begin
			take_bits(stim_lfsr, 27, r);
			pal_in = '{addr: r[26:19], data: r[18:1], wr: r[0]};
			#1;
			if (pal_out !== {r[26:19], widen_palette(r[18:1]), r[0]})
				report_mismatch("test_palette", 80'({r[26:19], widen_palette(r[18:1]), r[0]}),
					80'(pal_out));
			next_cycle();
		end
	endtask

	task automatic test_grav_clock();
		longint rate;
		longint expected;
		longint toggles;
		logic   prev;
		for (int k = 0; k < 2; k++) begin
			speed_sel = (k == 0) ? 3'd2 : 3'd6;
			rate      = (k == 0) ? longint'(`RATE_2) : longint'(`RATE_0);
			repeat (4) next_cycle();
			prev    = grav_clk;
			toggles = 0;
			repeat (3000) begin
				next_cycle();
				if (grav_clk !== prev)
					toggles++;
				prev = grav_clk;
			end
			expected = (longint'(3000) * `GRAV_STEP) / rate;
			if (toggles > expected + 1 || toggles + 1 < expected)
				report_mismatch("test_grav_clock", 80'(expected), 80'(toggles));
		end
	endtask

	task automatic test_leds();
		logic [31:0] addr;
		int          n;
		for (int dev = 1; dev >= 0; dev--) begin
			repeat (25) next_cycle();
			take_bits(stim_lfsr, 32, addr);
			host_access(1'b0, dev[0], addr, 32'd0, "test_leds");
			repeat (15) next_cycle();
			if ({led_hdd, led_fdd} !== ((dev == 1) ? 2'b10 : 2'b01))
				report_mismatch("test_leds", 80'((dev == 1) ? 2'b10 : 2'b01),
					80'({led_hdd, led_fdd}));
			n = 15;
			while ((led_hdd || led_fdd) && n < 25) begin
				next_cycle();
				n++;
			end
			if (led_hdd || led_fdd)
				report_failure("test_leds: LED still lit 25 cycles after io_wait fell");
		end
	endtask

	// ========================================
	// Run control
	// ========================================
	initial begin
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge clk_sys);
			cycle_count++;
		end
		$display("Timeout: run stopped after %0d cycles", TIMEOUT_CYCLES);
		$display("Test failed");
		$finish;
	end

	initial begin
		cpu_reset   = 1'b1;
		host_req    = '0;
		disk_device = 1'b0;
		mgmt_rsp    = '0;
		geom        = '0;
		rgb_order   = 1'b0;
		fmt_565     = 1'b0;
		pal_in      = '0;
		speed_sel   = 3'd0;
		repeat (4) @(posedge clk_sys);
		#1;
		cpu_reset = 1'b0;
		test_reset_values();
		test_host_write();
		test_host_read();
		test_fb_descriptor();
		test_palette();
		test_grav_clock();
		test_leds();
		$display("Errors: %0d mismatches, %0d other failures", value_errors, other_errors);
		if (value_errors + other_errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// File: files.f
+incdir+rtl
rtl/board_pkg.sv
rtl/host_bridge_ctrl.sv
rtl/fb_descriptor.sv
rtl/gravis_clock_gen.sv
rtl/activity_led.sv
rtl/board_glue_top.sv
test/tb_board_glue.sv
